//--- source/md_cfg.svh
// Shared sizing of the cell-list position cache
`ifndef MD_CFG_SVH
`define MD_CFG_SVH

// Bits per coordinate axis, a full position is three of these
`define POS_WIDTH 8

// Bits per cell coordinate on each axis
`define CELL_ID_WIDTH 2

// Slot address width, slot 0 holds the particle count
`define ADDR_WIDTH 4

// Most particles one cell can hold, in slots 1 and up
`define PARTICLE_NUM 15

// Cell grid size
`define GRID_X 2
`define GRID_Y 2
`define GRID_Z 1

// Total cells in the grid
`define NUM_CELLS (`GRID_X * `GRID_Y * `GRID_Z)

`endif

//--- source/md_pkg.sv
// Data types for particle positions, cell ids and cache memory words
`include "md_cfg.svh"

package md_pkg;

	// One particle position, z in the upper bits
	typedef struct packed
	{
		logic [`POS_WIDTH-1:0] z;
		logic [`POS_WIDTH-1:0] y;
		logic [`POS_WIDTH-1:0] x;
	} position_t;

	// Cell coordinate, cell_x in the upper bits
	typedef struct packed
	{
		logic [`CELL_ID_WIDTH-1:0] cell_x;
		logic [`CELL_ID_WIDTH-1:0] cell_y;
		logic [`CELL_ID_WIDTH-1:0] cell_z;
	} cell_id_t;

	// Address 0 view, zero padding above the particle count
	typedef struct packed
	{
		logic [3*`POS_WIDTH-`ADDR_WIDTH-1:0] pad;
		logic [`ADDR_WIDTH-1:0] count;
	} count_view_t;

	// One memory word, position in slots 1 and up, count at slot 0
	typedef union packed
	{
		position_t pos;
		count_view_t cnt;
	} cache_word_u;

endpackage

//--- source/motion_bus_if.sv
// Broadcast bus carrying the motion update stream to every cell
`timescale 1ns/1ps

interface motion_bus_if;

	// Held high for the whole update
	logic update_enable;
	// One-cycle strobe per particle, already masked by update_enable
	logic valid;
	// Cell the particle moves into
	md_pkg::cell_id_t dst_cell;
	// New particle position
	md_pkg::position_t data;

	// Broadcaster side
	modport source
	(
		output update_enable,
		output valid,
		output dst_cell,
		output data
	);

	// Cell side, every cell listens to the same wires
	modport sink
	(
		input update_enable,
		input valid,
		input dst_cell,
		input data
	);

endinterface

//--- source/motion_broadcast.sv
// Registers the external motion update stream and drives the shared broadcast bus
`timescale 1ns/1ps

module motion_broadcast
(
	input logic clk,
	input logic rst,
	input logic update_enable,
	input logic upd_valid,
	input md_pkg::cell_id_t upd_dst_cell,
	input md_pkg::position_t upd_data,
	motion_bus_if.source bus
);

	////////////////////////////////////////
	// Control stage
	////////////////////////////////////////

	// Enable and valid travel together so the cells see them aligned
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			bus.update_enable <= 1'b0;
			bus.valid <= 1'b0;
		end
		else
		begin
			bus.update_enable <= update_enable;
			// Stray strobes outside an update are dropped here
			bus.valid <= upd_valid & update_enable;
		end
	end

	////////////////////////////////////////
	// Payload stage
	////////////////////////////////////////

	// Fan-out point for destination and position to all cells
	always_ff @(posedge clk)
	begin
		bus.dst_cell <= upd_dst_cell;
		bus.data <= upd_data;
	end

endmodule

//--- source/cell_bank_ram.sv
// Single-port cell memory with registered read, starts as an empty cell
`timescale 1ns/1ps
`include "md_cfg.svh"

module cell_bank_ram
(
	input logic clk,
	input logic rden,
	input logic wren,
	input logic [`ADDR_WIDTH-1:0] address,
	input md_pkg::cache_word_u data,
	output md_pkg::cache_word_u q
);

	// Slot 0 for the count plus one slot per particle
	localparam int DEPTH = `PARTICLE_NUM + 1;

	md_pkg::cache_word_u mem [DEPTH];

	// Count and all slots read as zero until first written
	initial
	begin
		for (int i = 0; i < DEPTH; i++)
		begin
			mem[i] = '0;
		end
	end

	// Write port and registered read share one address
	always @(posedge clk)
	begin
		if (wren)
		begin
			mem[address] <= data;
		end
		// q keeps its last value while rden is low
		if (rden)
		begin
			q <= mem[address];
		end
	end

endmodule

//--- source/pos_cache.sv
// Double-buffered per-cell position cache with motion update controller and bank swap
`timescale 1ns/1ps
`include "md_cfg.svh"

module pos_cache
#(
	parameter int CELL_X = 0,
	parameter int CELL_Y = 0,
	parameter int CELL_Z = 0
)
(
	input logic clk,
	input logic rst,
	motion_bus_if.sink bus,
	input logic rd_en,
	input logic [`ADDR_WIDTH-1:0] rd_addr,
	output md_pkg::cache_word_u rd_data
);

	////////////////////////////////////////
	// Cell identity and match
	////////////////////////////////////////

	// Own coordinates as seen on the bus
	localparam md_pkg::cell_id_t OWN_ID = '{
		cell_x: `CELL_ID_WIDTH'(CELL_X),
		cell_y: `CELL_ID_WIDTH'(CELL_Y),
		cell_z: `CELL_ID_WIDTH'(CELL_Z)
	};

	// Valid is already masked by enable in the broadcaster
	logic dst_hit;
	assign dst_hit = bus.valid && (bus.dst_cell == OWN_ID);

	////////////////////////////////////////
	// Update controller
	////////////////////////////////////////

	localparam logic [1:0] ST_IDLE = 2'd0;
	localparam logic [1:0] ST_UPDATE = 2'd1;
	localparam logic [1:0] ST_WRITE_COUNT = 2'd2;
	localparam logic [1:0] ST_SWAP = 2'd3;

	logic [1:0] state;
	// Bank currently serving reads, the other one is the shadow
	logic active_cell;
	// Next free slot, one above the number recorded so far
	logic [`ADDR_WIDTH-1:0] new_particle_counter;
	// Registered write towards the shadow bank
	logic cell_wr_en;
	logic [`ADDR_WIDTH-1:0] cell_wr_addr;
	md_pkg::cache_word_u cell_wr_data;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= ST_IDLE;
			active_cell <= 1'b0;
			// Starts at 1 so slot 0 never takes a position
			new_particle_counter <= `ADDR_WIDTH'(1);
			cell_wr_en <= 1'b0;
		end
		else
		begin
			case (state)
				ST_IDLE:
				begin
					cell_wr_en <= 1'b0;
					if (bus.update_enable)
					begin
						// First particle may come with the enable edge
						cell_wr_en <= dst_hit;
						if (dst_hit)
						begin
							new_particle_counter <= new_particle_counter + 1'b1;
						end
						state <= ST_UPDATE;
					end
				end
				ST_UPDATE:
				begin
					cell_wr_en <= dst_hit;
					if (dst_hit)
					begin
						new_particle_counter <= new_particle_counter + 1'b1;
					end
					if (!bus.update_enable)
					begin
						state <= ST_WRITE_COUNT;
					end
				end
				ST_WRITE_COUNT:
				begin
					// Count lands at address 0 of the shadow bank
					cell_wr_en <= 1'b1;
					state <= ST_SWAP;
				end
				ST_SWAP:
				begin
					cell_wr_en <= 1'b0;
					// Shadow becomes active once the count is in
					active_cell <= ~active_cell;
					new_particle_counter <= `ADDR_WIDTH'(1);
					state <= ST_IDLE;
				end
				default:
				begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	// Write address and word, meaningful only with cell_wr_en
	always_ff @(posedge clk)
	begin
		if (state == ST_WRITE_COUNT)
		begin
			cell_wr_addr <= '0;
			cell_wr_data.cnt.pad <= '0;
			// Counter runs one ahead of the particle count
			cell_wr_data.cnt.count <= new_particle_counter - 1'b1;
		end
		else if (dst_hit)
		begin
			cell_wr_addr <= new_particle_counter;
			cell_wr_data.pos <= bus.data;
		end
	end

	////////////////////////////////////////
	// Bank crossing
	////////////////////////////////////////

	logic bank_rden [2];
	logic bank_wren [2];
	logic [`ADDR_WIDTH-1:0] bank_addr [2];
	md_pkg::cache_word_u bank_q [2];
	// Bank that answered the read in flight
	logic rd_bank;

	for (genvar b = 0; b < 2; b++)
	begin : g_bank
		// Active bank takes reads, shadow bank takes writes
		assign bank_rden[b] = rd_en && (active_cell == 1'(b));
		assign bank_wren[b] = cell_wr_en && (active_cell != 1'(b));
		assign bank_addr[b] = (active_cell == 1'(b)) ? rd_addr : cell_wr_addr;

		cell_bank_ram bank_i
		(
			.clk(clk),
			.rden(bank_rden[b]),
			.wren(bank_wren[b]),
			.address(bank_addr[b]),
			.data(cell_wr_data),
			.q(bank_q[b])
		);
	end

	// Keeps a read issued right at the swap on its own bank
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			rd_bank <= 1'b0;
		end
		else if (rd_en)
		begin
			rd_bank <= active_cell;
		end
	end

	assign rd_data = bank_q[rd_bank];

endmodule

//--- source/cell_read_select.sv
// Steers a read to one cell and returns its data with a valid pulse
`timescale 1ns/1ps
`include "md_cfg.svh"

module cell_read_select
(
	input logic clk,
	input logic rst,
	input logic rd_en,
	input md_pkg::cell_id_t rd_cell,
	input logic [`ADDR_WIDTH-1:0] rd_addr,
	output logic [`NUM_CELLS-1:0] cell_rd_en,
	output logic [`ADDR_WIDTH-1:0] cell_rd_addr,
	input md_pkg::cache_word_u [`NUM_CELLS-1:0] cell_rd_data,
	output md_pkg::cache_word_u rd_data,
	output logic rd_valid
);

	localparam int IDX_W = $clog2(`NUM_CELLS);

	////////////////////////////////////////
	// Request decode
	////////////////////////////////////////

	logic hit;
	logic [IDX_W-1:0] sel_idx;

	always_comb
	begin
		// Cells outside the grid are never enabled
		hit = (rd_cell.cell_x < `GRID_X) && (rd_cell.cell_y < `GRID_Y) &&
			(rd_cell.cell_z < `GRID_Z);
		// Same x-major order as the cell instances
		sel_idx = IDX_W'(rd_cell.cell_x * (`GRID_Y * `GRID_Z) +
			rd_cell.cell_y * `GRID_Z + rd_cell.cell_z);
		cell_rd_en = '0;
		cell_rd_en[sel_idx] = rd_en && hit;
	end

	// One address shared by all cells
	assign cell_rd_addr = rd_addr;

	////////////////////////////////////////
	// Return path
	////////////////////////////////////////

	logic hit_q;
	logic [IDX_W-1:0] sel_idx_q;

	// Selection follows the read by one cycle, like the memory output
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			rd_valid <= 1'b0;
			hit_q <= 1'b0;
			sel_idx_q <= '0;
		end
		else
		begin
			rd_valid <= rd_en;
			if (rd_en)
			begin
				hit_q <= hit;
				sel_idx_q <= sel_idx;
			end
		end
	end

	// Miss reads back as zero
	assign rd_data = hit_q ? cell_rd_data[sel_idx_q] : '0;

endmodule

//--- source/pos_cache_array_top.sv
// Grid of double-buffered position caches with broadcast update and selected read
`timescale 1ns/1ps
`include "md_cfg.svh"

module pos_cache_array_top
(
	input logic clk,
	input logic rst,
	input logic update_enable,
	input logic upd_valid,
	input md_pkg::cell_id_t upd_dst_cell,
	input md_pkg::position_t upd_data,
	input logic rd_en,
	input md_pkg::cell_id_t rd_cell,
	input logic [`ADDR_WIDTH-1:0] rd_addr,
	output md_pkg::cache_word_u rd_data,
	output logic rd_valid
);

	// Shared update stream
	motion_bus_if bus_if ();

	logic [`NUM_CELLS-1:0] cell_rd_en;
	logic [`ADDR_WIDTH-1:0] cell_rd_addr;
	md_pkg::cache_word_u [`NUM_CELLS-1:0] cell_rd_data;

	////////////////////////////////////////
	// Update input side
	////////////////////////////////////////

	motion_broadcast broadcast_i
	(
		.clk(clk),
		.rst(rst),
		.update_enable(update_enable),
		.upd_valid(upd_valid),
		.upd_dst_cell(upd_dst_cell),
		.upd_data(upd_data),
		.bus(bus_if.source)
	);

	////////////////////////////////////////
	// Cell caches
	////////////////////////////////////////

	// Cells numbered x-major, matching the read decode
	for (genvar gx = 0; gx < `GRID_X; gx++)
	begin : g_x
		for (genvar gy = 0; gy < `GRID_Y; gy++)
		begin : g_y
			for (genvar gz = 0; gz < `GRID_Z; gz++)
			begin : g_z
				localparam int IDX = gx * `GRID_Y * `GRID_Z + gy * `GRID_Z + gz;

				pos_cache
				#(
					.CELL_X(gx),
					.CELL_Y(gy),
					.CELL_Z(gz)
				)
				cache_i
				(
					.clk(clk),
					.rst(rst),
					.bus(bus_if.sink),
					.rd_en(cell_rd_en[IDX]),
					.rd_addr(cell_rd_addr),
					.rd_data(cell_rd_data[IDX])
				);
			end
		end
	end

	////////////////////////////////////////
	// Read output side
	////////////////////////////////////////

	cell_read_select read_select_i
	(
		.clk(clk),
		.rst(rst),
		.rd_en(rd_en),
		.rd_cell(rd_cell),
		.rd_addr(rd_addr),
		.cell_rd_en(cell_rd_en),
		.cell_rd_addr(cell_rd_addr),
		.cell_rd_data(cell_rd_data),
		.rd_data(rd_data),
		.rd_valid(rd_valid)
	);

endmodule

//--- tb/pos_cache_tb.sv
// Random self-checking testbench for the cell grid position cache
`timescale 1ns/1ps
`include "md_cfg.svh"

module pos_cache_tb;

	localparam int CLK_PERIOD = 40;
	localparam int RESET_CYCLES = 8;
	localparam int DRIVE_DELAY = 2;
	localparam int NUM_UPDATES = 4;
	localparam int UPDATE_ATTEMPTS = 40;
	localparam int SETTLE_CYCLES = 8;
	localparam int RANDOM_READS = 24;
	// Four updates of at most 400 cycles each with margin on top
	localparam int TIMEOUT_CYCLES = 2000;
	localparam int DEPTH = `PARTICLE_NUM + 1;
	localparam int NUM_CELLS = `NUM_CELLS;
	localparam int WORD_BITS = 3 * `POS_WIDTH;
	localparam int CELL_ID_BITS = 3 * `CELL_ID_WIDTH;

	logic clk;
	logic rst;
	logic update_enable;
	logic upd_valid;
	md_pkg::cell_id_t upd_dst_cell;
	md_pkg::position_t upd_data;
	logic rd_en;
	md_pkg::cell_id_t rd_cell;
	logic [`ADDR_WIDTH-1:0] rd_addr;
	md_pkg::cache_word_u rd_data;
	logic rd_valid;

	////////////////////////////////////////
	// Reference model state
	////////////////////////////////////////

	// Both banks of every cell and the bank that serves reads
	logic [WORD_BITS-1:0] model_mem [NUM_CELLS][2][DEPTH];
	logic model_active [NUM_CELLS];
	// Particles recorded in the current update
	int model_count [NUM_CELLS];

	// Read in flight is checked one cycle after issue
	logic read_pending;
	logic [WORD_BITS-1:0] read_expected;
	md_pkg::cell_id_t read_cell_q;
	logic [`ADDR_WIDTH-1:0] read_addr_q;

	int value_errors;
	int valid_errors;
	int cycle_count;
	int unsigned seed_state;

	pos_cache_array_top dut_i
	(
		.clk(clk),
		.rst(rst),
		.update_enable(update_enable),
		.upd_valid(upd_valid),
		.upd_dst_cell(upd_dst_cell),
		.upd_data(upd_data),
		.rd_en(rd_en),
		.rd_cell(rd_cell),
		.rd_addr(rd_addr),
		.rd_data(rd_data),
		.rd_valid(rd_valid)
	);

	initial
	begin
		clk = 1'b0;
	end

	always #(CLK_PERIOD / 2) clk = ~clk;

	////////////////////////////////////////
	// Grid helpers
	////////////////////////////////////////

	function automatic logic in_grid(input md_pkg::cell_id_t c);
		return (int'(c.cell_x) < `GRID_X) && (int'(c.cell_y) < `GRID_Y) &&
			(int'(c.cell_z) < `GRID_Z);
	endfunction

	// x-major numbering of the cells
	function automatic int cell_index(input md_pkg::cell_id_t c);
		return int'(c.cell_x) * (`GRID_Y * `GRID_Z) + int'(c.cell_y) * `GRID_Z +
			int'(c.cell_z);
	endfunction

	function automatic md_pkg::cell_id_t random_in_grid_cell();
		md_pkg::cell_id_t c;
		c.cell_x = `CELL_ID_WIDTH'($urandom_range(0, `GRID_X - 1));
		c.cell_y = `CELL_ID_WIDTH'($urandom_range(0, `GRID_Y - 1));
		c.cell_z = `CELL_ID_WIDTH'($urandom_range(0, `GRID_Z - 1));
		return c;
	endfunction

	// About one in eight goes to cell_x 3 outside the grid
	function automatic md_pkg::cell_id_t random_dest();
		md_pkg::cell_id_t c;
		c = random_in_grid_cell();
		if ($urandom_range(0, 7) == 0)
		begin
			c.cell_x = `CELL_ID_WIDTH'(3);
		end
		return c;
	endfunction

	function automatic md_pkg::cell_id_t random_read_cell();
		md_pkg::cell_id_t c;
		if ($urandom_range(0, 5) == 0)
		begin
			// Any coordinates and mostly outside the grid
			c = CELL_ID_BITS'($urandom);
		end
		else
		begin
			c = random_in_grid_cell();
		end
		return c;
	endfunction

	////////////////////////////////////////
	// Model operations
	////////////////////////////////////////

	task automatic model_reset();
		for (int c = 0; c < NUM_CELLS; c++)
		begin
			model_active[c] = 1'b0;
			model_count[c] = 0;
			for (int b = 0; b < 2; b++)
			begin
				for (int a = 0; a < DEPTH; a++)
				begin
					model_mem[c][b][a] = '0;
				end
			end
		end
	endtask

	// Arrival order into the shadow bank starting at slot 1
	task automatic model_record(input int idx, input logic [WORD_BITS-1:0] word);
		logic shadow;
		shadow = ~model_active[idx];
		model_count[idx]++;
		model_mem[idx][shadow][model_count[idx]] = word;
	endtask

	// Count goes to address 0 of the shadow before the banks trade places
	task automatic model_swap();
		logic shadow;
		for (int c = 0; c < NUM_CELLS; c++)
		begin
			shadow = ~model_active[c];
			model_mem[c][shadow][0] = WORD_BITS'(model_count[c]);
			model_active[c] = shadow;
			model_count[c] = 0;
		end
	endtask

	function automatic logic [WORD_BITS-1:0] model_read(input md_pkg::cell_id_t c,
		input logic [`ADDR_WIDTH-1:0] addr);
		int idx;
		if (!in_grid(c))
		begin
			return '0;
		end
		idx = cell_index(c);
		return model_mem[idx][model_active[idx]][addr];
	endfunction

	////////////////////////////////////////
	// Cycle and read handling
	////////////////////////////////////////

	task automatic check_read_return();
		if (read_pending)
		begin
			assert (rd_valid === 1'b1)
			else
			begin
				valid_errors++;
				$display("rd_valid missing after read of cell (%0d,%0d,%0d) slot %0d",
					read_cell_q.cell_x, read_cell_q.cell_y, read_cell_q.cell_z, read_addr_q);
			end
			assert (rd_data === read_expected)
			else
			begin
				value_errors++;
				$display("ERROR at %0d ns: cell (%0d,%0d,%0d) slot %0d read %h, expected %h",
					$time, read_cell_q.cell_x, read_cell_q.cell_y, read_cell_q.cell_z,
					read_addr_q, rd_data, read_expected);
			end
		end
		else
		begin
			assert (rd_valid === 1'b0)
			else
			begin
				valid_errors++;
				$display("rd_valid pulsed although no read was issued the cycle before");
			end
		end
		read_pending = 1'b0;
	endtask

	// Outputs are settled here and inputs change here too
	task automatic next_cycle();
		@(posedge clk);
		#DRIVE_DELAY;
		check_read_return();
	endtask

	task automatic drive_read(input md_pkg::cell_id_t c, input logic [`ADDR_WIDTH-1:0] addr);
		rd_en = 1'b1;
		rd_cell = c;
		rd_addr = addr;
		read_cell_q = c;
		read_addr_q = addr;
		read_expected = model_read(c, addr);
		read_pending = 1'b1;
	endtask

	task automatic random_read();
		if ($urandom_range(0, 1) == 0)
		begin
			drive_read(random_read_cell(), `ADDR_WIDTH'($urandom_range(0, DEPTH - 1)));
		end
		else
		begin
			rd_en = 1'b0;
		end
	endtask

	////////////////////////////////////////
	// Test phases
	////////////////////////////////////////

	// Strobes with update_enable low must be dropped
	task automatic stray_strobe();
		upd_valid = 1'($urandom_range(0, 1));
		upd_dst_cell = random_in_grid_cell();
		upd_data = WORD_BITS'($urandom);
	endtask

	task automatic idle_phase(input int cycles);
		for (int i = 0; i < cycles; i++)
		begin
			stray_strobe();
			random_read();
			next_cycle();
		end
		upd_valid = 1'b0;
		rd_en = 1'b0;
	endtask

	// Only cells set in mask take particles while reads see the old bank
	task automatic run_update(input int attempts, input logic [NUM_CELLS-1:0] mask);
		md_pkg::cell_id_t dest;
		logic [WORD_BITS-1:0] word;
		int idx;
		update_enable = 1'b1;
		for (int i = 0; i < attempts; i++)
		begin
			upd_valid = 1'b0;
			// Roughly one cycle in three is a gap
			if ($urandom_range(0, 2) != 0)
			begin
				dest = random_dest();
				word = WORD_BITS'($urandom);
				upd_dst_cell = dest;
				upd_data = word;
				if (!in_grid(dest))
				begin
					upd_valid = 1'b1;
				end
				else
				begin
					idx = cell_index(dest);
					// Sender side cap since the cells have no overflow protection
					if (mask[idx] && model_count[idx] < `PARTICLE_NUM)
					begin
						upd_valid = 1'b1;
						model_record(idx, word);
					end
				end
			end
			random_read();
			next_cycle();
		end
		update_enable = 1'b0;
		upd_valid = 1'b0;
		rd_en = 1'b0;
		model_swap();
		// Count write and swap complete well within this wait
		for (int i = 0; i < SETTLE_CYCLES; i++)
		begin
			stray_strobe();
			next_cycle();
		end
		upd_valid = 1'b0;
	endtask

	// Every slot of every cell and of one row outside the grid
	task automatic read_phase(input int random_reads);
		md_pkg::cell_id_t c;
		for (int x = 0; x <= `GRID_X; x++)
		begin
			for (int y = 0; y < `GRID_Y; y++)
			begin
				for (int z = 0; z < `GRID_Z; z++)
				begin
					c.cell_x = `CELL_ID_WIDTH'(x);
					c.cell_y = `CELL_ID_WIDTH'(y);
					c.cell_z = `CELL_ID_WIDTH'(z);
					for (int a = 0; a < DEPTH; a++)
					begin
						drive_read(c, `ADDR_WIDTH'(a));
						next_cycle();
					end
				end
			end
		end
		for (int i = 0; i < random_reads; i++)
		begin
			random_read();
			next_cycle();
		end
		rd_en = 1'b0;
		next_cycle();
	endtask

	////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////

	initial
	begin
		logic [NUM_CELLS-1:0] mask;
		seed_state = $urandom(32'h64067a35);
		value_errors = 0;
		valid_errors = 0;
		read_pending = 1'b0;
		read_expected = '0;
		read_cell_q = '0;
		read_addr_q = '0;
		rst = 1'b1;
		update_enable = 1'b0;
		upd_valid = 1'b0;
		upd_dst_cell = '0;
		upd_data = '0;
		rd_en = 1'b0;
		rd_cell = '0;
		rd_addr = '0;
		model_reset();

		repeat (RESET_CYCLES) @(posedge clk);
		#DRIVE_DELAY;
		rst = 1'b0;

		// First check also covers rd_valid low after reset
		idle_phase(6);

		for (int u = 0; u < NUM_UPDATES; u++)
		begin
			mask = '1;
			// Last update leaves the middle cells empty
			if (u == NUM_UPDATES - 1)
			begin
				mask = '0;
				mask[0] = 1'b1;
				mask[NUM_CELLS-1] = 1'b1;
			end
			run_update(UPDATE_ATTEMPTS, mask);
			read_phase(RANDOM_READS);
		end

		$display("Run complete: %0d value errors, %0d rd_valid errors",
			value_errors, valid_errors);
		if (value_errors + valid_errors == 0)
		begin
			$display("TEST PASS");
		end
		else
		begin
			$display("TEST FAIL");
		end
		$finish;
	end

	// Run limit in clock cycles
	initial
	begin
		cycle_count = 0;
		while (cycle_count < TIMEOUT_CYCLES)
		begin
			@(posedge clk);
			cycle_count++;
		end
		$display("Timed out after %0d cycles, %0d value errors, %0d rd_valid errors",
			TIMEOUT_CYCLES, value_errors, valid_errors);
		$display("TEST FAIL");
		$finish;
	end

endmodule

//--- src.f
+incdir+source
source/md_pkg.sv
source/motion_bus_if.sv
source/motion_broadcast.sv
source/cell_bank_ram.sv
source/pos_cache.sv
source/cell_read_select.sv
source/pos_cache_array_top.sv
tb/pos_cache_tb.sv

//--- Makefile
# Verilator build and run for the position cache testbench

VERILATOR = verilator
VFLAGS = --binary --timing --assert
TOP = pos_cache_tb
FILELIST = src.f
OBJ_DIR = obj_dir
LOG = sim.log

SIM_BIN = $(OBJ_DIR)/V$(TOP)
SOURCES = $(shell grep -v '^+' $(FILELIST)) $(wildcard source/*.svh)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FILELIST)

# Fails unless the log holds the pass line
run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -qx "TEST PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
